// File: source/i2c_pkg.sv
// shared command, response and width types, imported by the i2c master RTL and its testbench
`default_nettype none

package i2c_pkg;

	// ------------------------------------------------------------
	// widths that carry a meaning on the bus
	// ------------------------------------------------------------

	// one data byte on sda
	typedef logic [7:0] byte_t;

	// quarter-bit phase inside one operation, 36 for a byte plus ack
	typedef logic [5:0] phase_t;

	// ------------------------------------------------------------
	// host commands and responses
	// ------------------------------------------------------------

	typedef enum logic [1:0] {
		OP_START = 2'd0,
		OP_STOP  = 2'd1,
		OP_SEND  = 2'd2,
		OP_RECV  = 2'd3
	} i2c_op_t;

	typedef struct packed {
		i2c_op_t op;
		// byte to send, only meaningful on OP_SEND
		byte_t   data;
		// on OP_RECV, release sda in the ack slot
		logic    nack;
	} i2c_cmd_t;

	typedef struct packed {
		// byte seen on sda during the eight data bits
		byte_t data;
		// sda level in the ack slot, low means acknowledged
		logic  ack;
	} i2c_rsp_t;

endpackage

`default_nettype wire

// File: source/i2c_cmd_decode.sv
// decode stage: takes one host command over the req/ack handshake and starts the bit engine
`timescale 1ns/1ps
`default_nettype none

module i2c_cmd_decode
	import i2c_pkg::*;
(
	input  wire           clk,
	input  wire           reset,

	// host side, four-phase handshake
	input  wire           cmd_req_i,
	input  wire i2c_cmd_t cmd_i,
	output logic          cmd_ack_o,

	// bit engine side
	output logic          eng_start_o,
	output i2c_cmd_t      eng_cmd_o,
	input  wire           eng_done_i
);

	typedef enum logic [1:0] {
		IDLE,
		RUN,
		ACK,
		RELEASE
	} state_t;

	state_t   state_q;
	logic     start_q;
	i2c_cmd_t cmd_q;

	// ------------------------------------------------------------
	// handshake FSM
	// ------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (reset) begin
			state_q <= IDLE;
			start_q <= 1'b0;
		end else begin
			start_q <= 1'b0;
			case (state_q)
				IDLE: begin
					// request is always fresh here, ack has already fallen
					if (cmd_req_i) begin
						state_q <= RUN;
						start_q <= 1'b1;
					end
				end
				RUN: begin
					if (eng_done_i)
						state_q <= ACK;
				end
				ACK: begin
					// host holds req high as long as it wants the response
					if (!cmd_req_i)
						state_q <= RELEASE;
				end
				default: begin
					state_q <= IDLE;
				end
			endcase
		end
	end

	// command held for the engine during the whole operation
	always_ff @(posedge clk) begin
		if (state_q == IDLE && cmd_req_i)
			cmd_q <= cmd_i;
	end

	assign cmd_ack_o   = (state_q == ACK);
	assign eng_start_o = start_q;
	assign eng_cmd_o   = cmd_q;

endmodule

`default_nettype wire

// File: source/i2c_bit_engine.sv
// execute stage that runs one bus operation in quarter-bit phases on the open-drain scl and sda lines
`timescale 1ns/1ps
`default_nettype none

module i2c_bit_engine
	import i2c_pkg::*;
#(
	parameter int DIVIDER_WIDTH = 16
) (
	input  wire                     clk,
	input  wire                     reset,

	// clocks per quarter-bit phase minus one
	input  wire [DIVIDER_WIDTH-1:0] divider_i,

	input  wire                     start_i,
	input  wire i2c_cmd_t           cmd_i,
	output logic                    done_o,

	// open-drain pins with high meaning released
	output logic                    scl_t_o,
	output logic                    sda_t_o,
	input  wire                     scl_i,
	input  wire                     sda_i,

	// to the result stage
	output logic                    sample_o,
	output logic                    sample_sda_o,
	output logic                    ack_slot_o
);

	// last quarter phase of each kind of operation
	localparam phase_t LAST_COND = 6'd2;
	localparam phase_t LAST_BYTE = 6'd35;

	logic                     scl_meta;
	logic                     scl_sync;
	logic                     sda_meta;
	logic                     sda_sync;

	logic                     busy_q;
	i2c_op_t                  op_q;
	byte_t                    data_q;
	logic                     nack_q;
	phase_t                   phase_q;
	phase_t                   phase_nxt;
	logic [DIVIDER_WIDTH-1:0] div_cnt_q;
	logic                     done_q;

	logic                     scl_t_q;
	logic                     sda_t_q;
	logic [1:0]               lines_cur;
	logic [1:0]               lines_nxt;
	logic                     settled;
	logic                     stall;
	logic                     tick;
	logic                     last_phase;

	// {scl, sda} release levels for one quarter phase of an operation
	function automatic logic [1:0] bus_levels(
		i2c_op_t op,
		phase_t  ph,
		byte_t   data,
		logic    nack
	);
		logic       scl_high;
		logic       data_bit;
		logic [1:0] lv;
		scl_high = (ph[1:0] == 2'b01) || (ph[1:0] == 2'b10);
		// ph[4:2] counts the bit from bit 7 down
		data_bit = data[~ph[4:2]];
		case (op)
			OP_START: begin
				case (ph[1:0])
					2'b00:   lv = 2'b11;
					2'b01:   lv = 2'b10;
					default: lv = 2'b00;
				endcase
			end
			OP_STOP: begin
				case (ph[1:0])
					2'b00:   lv = 2'b00;
					2'b01:   lv = 2'b10;
					default: lv = 2'b11;
				endcase
			end
			// ack slot released so the slave can answer
			OP_SEND: lv = {scl_high, ph[5] | data_bit};
			default: lv = {scl_high, ph[5] ? nack : 1'b1};
		endcase
		return lv;
	endfunction

	// ------------------------------------------------------------
	// two-flop synchronisers on the returning bus lines
	// ------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (reset) begin
			scl_meta <= 1'b1;
			scl_sync <= 1'b1;
			sda_meta <= 1'b1;
			sda_sync <= 1'b1;
		end else begin
			scl_meta <= scl_i;
			scl_sync <= scl_meta;
			sda_meta <= sda_i;
			sda_sync <= sda_meta;
		end
	end

	// ------------------------------------------------------------
	// quarter-phase timing
	// ------------------------------------------------------------

	assign lines_cur = bus_levels(op_q, phase_q, data_q, nack_q);
	assign lines_nxt = bus_levels(op_q, phase_nxt, data_q, nack_q);
	assign phase_nxt = phase_q + 6'd1;

	// both lines must match the phase before counting starts
	assign settled = ({scl_t_q, sda_t_q} == lines_cur);

	// scl released but still read low while a slave stretches
	assign stall = (scl_t_q && !scl_sync) || !settled;
	assign tick  = busy_q && !stall && (div_cnt_q == '0);

	assign last_phase = (op_q == OP_START || op_q == OP_STOP) ?
		(phase_q == LAST_COND) : (phase_q == LAST_BYTE);

	always_ff @(posedge clk) begin
		if (reset)
			div_cnt_q <= '0;
		else if (!busy_q || tick)
			div_cnt_q <= divider_i;
		else if (!stall)
			div_cnt_q <= div_cnt_q - DIVIDER_WIDTH'(1);
	end

	always_ff @(posedge clk) begin
		if (start_i) begin
			op_q   <= cmd_i.op;
			data_q <= cmd_i.data;
			nack_q <= cmd_i.nack;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			busy_q  <= 1'b0;
			phase_q <= '0;
			done_q  <= 1'b0;
		end else begin
			done_q <= tick && last_phase;
			if (start_i) begin
				busy_q  <= 1'b1;
				phase_q <= '0;
			end else if (tick) begin
				if (last_phase)
					busy_q <= 1'b0;
				else
					phase_q <= phase_nxt;
			end
		end
	end

	// ------------------------------------------------------------
	// line drivers
	// ------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (reset) begin
			scl_t_q <= 1'b1;
			sda_t_q <= 1'b1;
		end else if (start_i) begin
			// start lifts sda before scl and everything else drops scl first
			if (cmd_i.op == OP_START)
				sda_t_q <= 1'b1;
			else
				scl_t_q <= 1'b0;
		end else if (tick && !last_phase) begin
			{scl_t_q, sda_t_q} <= lines_nxt;
		end else if (busy_q) begin
			{scl_t_q, sda_t_q} <= lines_cur;
		end
	end

	assign scl_t_o = scl_t_q;
	assign sda_t_o = sda_t_q;
	assign done_o  = done_q;

	// end of the second quarter after a full phase of scl high
	assign sample_o     = tick && (phase_q[1:0] == 2'b01) &&
		(op_q == OP_SEND || op_q == OP_RECV);
	assign sample_sda_o = sda_sync;
	assign ack_slot_o   = phase_q[5];

endmodule

`default_nettype wire

// File: source/i2c_result.sv
// result stage: collects the sampled sda bits into the received byte and ack, and holds the response
`timescale 1ns/1ps
`default_nettype none

module i2c_result
	import i2c_pkg::*;
(
	input  wire      clk,
	input  wire      reset,

	// sample strobe and synchronised sda from the bit engine
	input  wire      sample_i,
	input  wire      sda_i,
	input  wire      ack_slot_i,

	output i2c_rsp_t rsp_o
);

	byte_t    shift_q;
	i2c_rsp_t rsp_q;

	// ------------------------------------------------------------
	// data bits, msb first
	// ------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (sample_i && !ack_slot_i)
			shift_q <= {shift_q[6:0], sda_i};
	end

	// ------------------------------------------------------------
	// response register
	// ------------------------------------------------------------

	// updated only in the ack slot, so the previous
	// response stays intact while a byte is in progress
	always_ff @(posedge clk) begin
		if (reset) begin
			rsp_q <= '0;
		end else if (sample_i && ack_slot_i) begin
			rsp_q.data <= shift_q;
			rsp_q.ack  <= sda_i;
		end
	end

	assign rsp_o = rsp_q;

endmodule

`default_nettype wire

// File: source/i2c_master_top.sv
// i2c master top level: connects command decode, bit engine and result stage to the host and bus pins
`timescale 1ns/1ps
`default_nettype none

module i2c_master_top
	import i2c_pkg::*;
#(
	parameter int DIVIDER_WIDTH = 16
) (
	input  wire                     clk,
	input  wire                     reset,

	input  wire [DIVIDER_WIDTH-1:0] divider_i,

	// host handshake
	input  wire                     cmd_req_i,
	input  wire i2c_cmd_t           cmd_i,
	output logic                    cmd_ack_o,
	output i2c_rsp_t                rsp_o,

	// bus pins
	output logic                    scl_t_o,
	input  wire                     scl_i,
	output logic                    sda_t_o,
	input  wire                     sda_i
);

	logic     eng_start;
	i2c_cmd_t eng_cmd;
	logic     eng_done;
	logic     sample;
	logic     sample_sda;
	logic     ack_slot;

	i2c_cmd_decode u_decode (
		.clk         (clk),
		.reset       (reset),
		.cmd_req_i   (cmd_req_i),
		.cmd_i       (cmd_i),
		.cmd_ack_o   (cmd_ack_o),
		.eng_start_o (eng_start),
		.eng_cmd_o   (eng_cmd),
		.eng_done_i  (eng_done)
	);

	i2c_bit_engine #(
		.DIVIDER_WIDTH (DIVIDER_WIDTH)
	) u_engine (
		.clk          (clk),
		.reset        (reset),
		.divider_i    (divider_i),
		.start_i      (eng_start),
		.cmd_i        (eng_cmd),
		.done_o       (eng_done),
		.scl_t_o      (scl_t_o),
		.sda_t_o      (sda_t_o),
		.scl_i        (scl_i),
		.sda_i        (sda_i),
		.sample_o     (sample),
		.sample_sda_o (sample_sda),
		.ack_slot_o   (ack_slot)
	);

	i2c_result u_result (
		.clk        (clk),
		.reset      (reset),
		.sample_i   (sample),
		.sda_i      (sample_sda),
		.ack_slot_i (ack_slot),
		.rsp_o      (rsp_o)
	);

endmodule

`default_nettype wire

// File: test/i2c_slave_model.sv
// behavioural i2c slave for the testbench: random read data, random ack and random clock stretching
`timescale 1ns/1ps
`default_nettype none

module i2c_slave_model
	import i2c_pkg::*;
(
	input  wire          clk,
	input  wire          reset,
	// direction of the current transfer, the model decodes no address
	input  wire i2c_op_t host_op_i,
	input  wire          scl_i,
	input  wire          sda_i,
	output logic         scl_t_o,
	output logic         sda_t_o
);

	localparam int MAX_STRETCH = 20;

	logic       scl_q;
	logic       sda_q;
	logic [3:0] bit_cnt;
	int         stretch;
	byte_t      reply;
	logic       ack_bit;

	always @(posedge clk) begin
		if (reset) begin
			scl_q   <= 1'b1;
			sda_q   <= 1'b1;
			bit_cnt <= '0;
			stretch <= 0;
			reply   <= byte_t'($urandom);
			ack_bit <= 1'($urandom);
			scl_t_o <= 1'b1;
			sda_t_o <= 1'b1;
		end else begin
			scl_q <= scl_i;
			sda_q <= sda_i;

			// nine slots per byte, new reply and ack after the last one
			if (scl_i && !scl_q) begin
				if (bit_cnt == 4'd8) begin
					bit_cnt <= '0;
					reply   <= byte_t'($urandom);
					ack_bit <= 1'($urandom);
				end else begin
					bit_cnt <= bit_cnt + 4'd1;
				end
			end
			// start or stop, next byte begins at slot zero
			if (scl_i && scl_q && sda_i != sda_q)
				bit_cnt <= '0;

			// hold scl low for a while after every falling edge
			if (!scl_i && scl_q)
				stretch <= $urandom_range(0, MAX_STRETCH);
			else if (stretch > 0)
				stretch <= stretch - 1;
			scl_t_o <= (stretch == 0);

			// sda only changes while scl is low
			if (!scl_i) begin
				if (host_op_i == OP_RECV && bit_cnt < 4'd8)
					sda_t_o <= reply[3'd7 - bit_cnt[2:0]];
				else if (host_op_i == OP_SEND && bit_cnt == 4'd8)
					sda_t_o <= ack_bit;
				else
					sda_t_o <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: test/i2c_checker.sv
// checker for the i2c master testbench that decodes the bus lines on its own and compares each response
`timescale 1ns/1ps
`default_nettype none

module i2c_checker
	import i2c_pkg::*;
(
	input  wire           clk,
	input  wire           reset,
	input  wire           cmd_req_i,
	input  wire i2c_cmd_t cmd_i,
	input  wire           cmd_ack_i,
	input  wire i2c_rsp_t rsp_i,
	input  wire           scl_i,
	input  wire           sda_i,
	output int            checks_o,
	output int            errors_o
);

	int         checks = 0;
	int         errors = 0;
	logic       req_q;
	logic       ack_q;
	logic       scl_q;
	logic       sda_q;
	logic       seen_req;
	logic       start_seen;
	logic       stop_seen;
	int         bits;
	// eight data bits then the ack slot with the oldest on the left
	logic [8:0] shift;
	// response decoded from the last byte on the bus
	logic [8:0] last_rsp;
	i2c_cmd_t   cmd_q;

	assign checks_o = checks;
	assign errors_o = errors;

	task automatic check_value(input string what, input int got, input int exp);
		checks++;
		if (got != exp) begin
			errors++;
			$display("ERR %0t: %s is %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	// expected response follows from the bus activity since the request rose
	task automatic check_response;
		check_value("request at ack rise", int'(cmd_req_i), 1);
		case (cmd_q.op)
			OP_START: begin
				check_value("start and stop seen", int'({start_seen, stop_seen}), 2);
				check_value("rsp_o held over start", int'(rsp_i), int'(last_rsp));
			end
			OP_STOP: begin
				check_value("start and stop seen", int'({start_seen, stop_seen}), 1);
				check_value("rsp_o held over stop", int'(rsp_i), int'(last_rsp));
			end
			default: begin
				check_value("bit slots in a byte", bits, 9);
				check_value("conditions inside a byte", int'({start_seen, stop_seen}), 0);
				if (cmd_q.op == OP_SEND)
					check_value("byte sent on the bus", int'(shift[8:1]), int'(cmd_q.data));
				else
					check_value("master ack slot level", int'(shift[0]), int'(cmd_q.nack));
				check_value("rsp_o.data", int'(rsp_i.data), int'(shift[8:1]));
				check_value("rsp_o.ack", int'(rsp_i.ack), int'(shift[0]));
			end
		endcase
	endtask

	// ------------------------------------------------------------
	// bus decode and handshake watch
	// ------------------------------------------------------------

	always @(posedge clk) begin
		if (reset) begin
			req_q      <= 1'b0;
			ack_q      <= 1'b0;
			scl_q      <= 1'b1;
			sda_q      <= 1'b1;
			seen_req   <= 1'b0;
			start_seen <= 1'b0;
			stop_seen  <= 1'b0;
			bits       <= 0;
			shift      <= '0;
			last_rsp   <= '0;
		end else begin
			req_q <= cmd_req_i;
			ack_q <= cmd_ack_i;
			scl_q <= scl_i;
			sda_q <= sda_i;
			if (cmd_req_i && !req_q) begin
				seen_req   <= 1'b1;
				cmd_q      <= cmd_i;
				start_seen <= 1'b0;
				stop_seen  <= 1'b0;
				bits       <= 0;
			end
			// sda moving while scl stays high
			if (scl_i && scl_q && sda_i != sda_q) begin
				if (sda_i)
					stop_seen <= 1'b1;
				else
					start_seen <= 1'b1;
			end
			// one bit per scl rise
			if (scl_i && !scl_q) begin
				bits  <= bits + 1;
				shift <= {shift[7:0], sda_i};
			end
			if (!seen_req) begin
				check_value("idle ack, scl, sda", int'({cmd_ack_i, scl_i, sda_i}), 3);
				check_value("idle rsp_o", int'(rsp_i), 0);
			end
			if (cmd_ack_i && !ack_q) begin
				check_response();
				if (cmd_q.op == OP_SEND || cmd_q.op == OP_RECV)
					last_rsp <= shift;
			end
			if (!cmd_ack_i && ack_q)
				check_value("request at ack fall", int'(cmd_req_i), 0);
		end
	end

endmodule

`default_nettype wire

// File: test/i2c_tb.sv
// testbench top for the i2c master: clock, reset, wired-AND bus and a random command sequence
`timescale 1ns/1ps
`default_nettype none

module i2c_tb
	import i2c_pkg::*;
();

	localparam int CLK_PERIOD  = 40;
	localparam int SEED        = 32'heed7;
	localparam int NUM_CMDS    = 200;
	localparam int ACK_TIMEOUT = 5000;
	localparam int DIV_W       = 16;

	logic             clk = 1'b0;
	logic             reset;
	logic [DIV_W-1:0] divider;
	logic             cmd_req;
	i2c_cmd_t         cmd;
	logic             cmd_ack;
	i2c_rsp_t         rsp;
	logic             dut_scl_t;
	logic             dut_sda_t;
	logic             slv_scl_t;
	logic             slv_sda_t;
	wire              scl;
	wire              sda;
	int               checks;
	int               errors;
	int               timeouts = 0;

	// open-drain bus, low wins
	assign scl = dut_scl_t & slv_scl_t;
	assign sda = dut_sda_t & slv_sda_t;

	always #(CLK_PERIOD / 2) clk = ~clk;

	i2c_master_top #(
		.DIVIDER_WIDTH (DIV_W)
	) dut_i (
		.clk       (clk),
		.reset     (reset),
		.divider_i (divider),
		.cmd_req_i (cmd_req),
		.cmd_i     (cmd),
		.cmd_ack_o (cmd_ack),
		.rsp_o     (rsp),
		.scl_t_o   (dut_scl_t),
		.scl_i     (scl),
		.sda_t_o   (dut_sda_t),
		.sda_i     (sda)
	);

	i2c_slave_model slave_i (
		.clk       (clk),
		.reset     (reset),
		.host_op_i (cmd.op),
		.scl_i     (scl),
		.sda_i     (sda),
		.scl_t_o   (slv_scl_t),
		.sda_t_o   (slv_sda_t)
	);

	i2c_checker checker_i (
		.clk       (clk),
		.reset     (reset),
		.cmd_req_i (cmd_req),
		.cmd_i     (cmd),
		.cmd_ack_i (cmd_ack),
		.rsp_i     (rsp),
		.scl_i     (scl),
		.sda_i     (sda),
		.checks_o  (checks),
		.errors_o  (errors)
	);

	task automatic wait_ack(input logic level, input string what);
		int n;
		n = 0;
		while (cmd_ack !== level && n < ACK_TIMEOUT) begin
			@(posedge clk);
			n++;
		end
		if (cmd_ack !== level) begin
			$display("timeout: cmd_ack did not %s within %0d cycles", what, ACK_TIMEOUT);
			timeouts++;
		end
	endtask

	// one full four-phase handshake, req held a few random cycles after ack
	task automatic run_cmd(input i2c_cmd_t c);
		@(posedge clk);
		cmd_req <= 1'b1;
		cmd     <= c;
		wait_ack(1'b1, "rise");
		if (timeouts == 0) begin
			repeat ($urandom_range(0, 3)) @(posedge clk);
			cmd_req <= 1'b0;
			wait_ack(1'b0, "fall");
		end
	endtask

	initial begin
		i2c_cmd_t c;
		void'($urandom(SEED));
		reset   <= 1'b1;
		cmd_req <= 1'b0;
		cmd     <= '0;
		divider <= DIV_W'($urandom_range(1, 6));
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		repeat (4) @(posedge clk);

		for (int i = 0; i < NUM_CMDS && timeouts == 0; i++) begin
			c.op   = i2c_op_t'(2'($urandom_range(0, 3)));
			c.data = byte_t'($urandom);
			c.nack = 1'($urandom);
			run_cmd(c);
		end
		repeat (4) @(posedge clk);

		$display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0 && checks > 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: files.f
source/i2c_pkg.sv
source/i2c_cmd_decode.sv
source/i2c_bit_engine.sv
source/i2c_result.sv
source/i2c_master_top.sv
test/i2c_slave_model.sv
test/i2c_checker.sv
test/i2c_tb.sv

// File: run.sh
#!/bin/sh
# builds the testbench with verilator, runs it and looks for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f files.f --top-module i2c_tb -o i2c_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/i2c_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "RESULT: PASS"; then
	exit 0
else
	echo "pass line not found in simulation output"
	exit 1
fi
